// ==== Makefile ====
# Verilator build and run for the machine-mode trap unit

TOP = priv_unit_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
hdl/priv_pkg.sv
hdl/trap_prioritizer.sv
hdl/trap_sequencer.sv
hdl/mtime_timer.sv
hdl/machine_csrs.sv
hdl/priv_unit.sv
tb/priv_unit_tb.sv

// ==== hdl/machine_csrs.sv ====
// Machine CSR file
// mstatus, mie, mip, mcause, mepc and mtval registers
// Trap capture, commit and mret restore over software writes
// Combinational read port and mtimecmp write decode

`timescale 1ns/1ps

module machine_csrs import priv_pkg::*; (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             capture,
    input  logic             commit,
    input  logic             restore,
    input  trap_info_t       trap_info,
    input  logic             ext_irq,
    input  logic             mtip,
    input  logic             csr_we,
    input  csr_addr_t        csr_addr,
    input  logic [XLEN-1:0]  csr_wdata,
    input  logic [XLEN-1:0]  mtimecmp,
    output logic [XLEN-1:0]  csr_rdata,
    output logic             mtimecmp_we,
    output mstatus_t         mstatus,
    output mie_t             mie,
    output mip_t             mip,
    output mcause_t          mcause,
    output logic [XLEN-1:0]  mepc,
    output logic [XLEN-1:0]  mtval
);

    logic meip_q; // External level after one register stage
    logic msip_q; // Software pending bit

    assign mtimecmp_we = csr_we & (csr_addr == MTIMECMP_ADDR);

    // mtip comes straight from the timer
    assign mip = '{meip: meip_q, mtip: mtip, msip: msip_q};

    // mstatus: commit, then mret, then software
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mstatus <= '0;
        end
        else if (commit) begin
            mstatus.mpie <= mstatus.mie;
            mstatus.mie  <= 1'b0;
        end
        else if (restore) begin
            mstatus.mie  <= mstatus.mpie;
            mstatus.mpie <= 1'b0;
        end
        else if (csr_we && csr_addr == MSTATUS_ADDR) begin
            mstatus <= '{mpie: csr_wdata[7], mie: csr_wdata[3]};
        end
    end

    // Enables and the writable pending bit
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mie    <= '0;
            msip_q <= 1'b0;
            meip_q <= 1'b0;
        end
        else begin
            meip_q <= ext_irq;
            if (csr_we && csr_addr == MIE_ADDR)
                mie <= '{meie: csr_wdata[11], mtie: csr_wdata[7], msie: csr_wdata[3]};
            if (csr_we && csr_addr == MIP_ADDR)
                msip_q <= csr_wdata[3]; // meip and mtip are read only
        end
    end

    // Trap state registers, capture wins over a same-cycle write
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mcause <= '0;
            mepc   <= '0;
            mtval  <= '0;
        end
        else if (capture) begin
            mcause <= trap_info.cause;
            mepc   <= trap_info.epc;
            mtval  <= trap_info.tval;
        end
        else if (csr_we) begin
            if (csr_addr == MCAUSE_ADDR) mcause <= mcause_t'(csr_wdata);
            if (csr_addr == MEPC_ADDR)   mepc   <= {csr_wdata[XLEN-1:2], 2'b00}; // IALIGN 32
            if (csr_addr == MTVAL_ADDR)  mtval  <= csr_wdata;
        end
    end

    // Read port, unimplemented bits read as zero
    always_comb begin
        csr_rdata = '0;
        case (csr_addr)
            MSTATUS_ADDR: begin
                csr_rdata[7] = mstatus.mpie;
                csr_rdata[3] = mstatus.mie;
            end
            MIE_ADDR:      csr_rdata = {20'b0, mie.meie, 3'b0, mie.mtie, 3'b0, mie.msie, 3'b0};
            MIP_ADDR:      csr_rdata = {20'b0, mip.meip, 3'b0, mip.mtip, 3'b0, mip.msip, 3'b0};
            MCAUSE_ADDR:   csr_rdata = mcause;
            MEPC_ADDR:     csr_rdata = mepc;
            MTVAL_ADDR:    csr_rdata = mtval;
            MTIMECMP_ADDR: csr_rdata = mtimecmp;
            default:       csr_rdata = '0;
        endcase
    end

endmodule

// ==== hdl/mtime_timer.sv ====
// Machine timer
// Prescale divider, free running mtime counter,
// writable mtimecmp and the timer pending level

`timescale 1ns/1ps

module mtime_timer import priv_pkg::*; #(
    parameter int PRESCALE = 4  // Clocks per mtime tick
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             cmp_we,
    input  logic [XLEN-1:0]  cmp_wdata,
    output logic [XLEN-1:0]  mtimecmp,
    output logic             mtip
);

    localparam int PW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    logic [PW-1:0]   pre_cnt;
    logic            tick;
    logic [XLEN-1:0] mtime;

    assign tick = (pre_cnt == PW'(PRESCALE - 1)); // Last clock of the period

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pre_cnt  <= '0;
            mtime    <= '0;
        end
        else if (tick) begin
            pre_cnt <= '0;
            mtime   <= mtime + 1'b1; // Wraps at 2^32
        end
        else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // Compare value, all ones after reset so no timer trap fires early
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mtimecmp <= '1;
        end
        else if (cmp_we) begin
            mtimecmp <= cmp_wdata;
        end
    end

    assign mtip = (mtime >= mtimecmp); // Level, cleared by raising mtimecmp

endmodule

// ==== hdl/priv_pkg.sv ====
// Machine-mode privilege definitions for the RV32 trap unit
// Cause code enums for exceptions and interrupts
// CSR address constants, including the custom mtimecmp slot
// Packed CSR images and the pipeline request and trap info structs

package priv_pkg;

    parameter int XLEN = 32; // Data width

    typedef logic [11:0] csr_addr_t; // CSR address field from the instruction

    // Synchronous exception causes, mcause.interrupt = 0
    typedef enum logic [30:0] {
        INSN_MAL     = 31'd0,
        INSN_ACCESS  = 31'd1,
        ILLEGAL_INSN = 31'd2,
        BREAKPOINT   = 31'd3,
        L_ADDR_MAL   = 31'd4,
        L_FAULT      = 31'd5,
        S_ADDR_MAL   = 31'd6,
        S_FAULT      = 31'd7,
        ENV_CALL_M   = 31'd11
    } ex_code_t;

    // Machine interrupt causes, mcause.interrupt = 1
    typedef enum logic [30:0] {
        SOFT_INT_M  = 31'd3,
        TIMER_INT_M = 31'd7,
        EXT_INT_M   = 31'd11
    } int_code_t;

    // CSR addresses
    localparam csr_addr_t MSTATUS_ADDR  = 12'h300;
    localparam csr_addr_t MIE_ADDR      = 12'h304;
    localparam csr_addr_t MEPC_ADDR     = 12'h341;
    localparam csr_addr_t MCAUSE_ADDR   = 12'h342;
    localparam csr_addr_t MTVAL_ADDR    = 12'h343;
    localparam csr_addr_t MIP_ADDR      = 12'h344;
    localparam csr_addr_t MTIMECMP_ADDR = 12'h7C0; // Custom machine R/W space

    // Only the machine bits are implemented, read back at bits 7 and 3
    typedef struct packed {
        logic mpie;
        logic mie;
    } mstatus_t;

    typedef struct packed {
        logic meie; // Read at bit 11
        logic mtie; // Bit 7
        logic msie; // Bit 3
    } mie_t;

    typedef struct packed {
        logic meip;
        logic mtip;
        logic msip;
    } mip_t;

    typedef struct packed {
        logic        interrupt;
        logic [30:0] cause;
    } mcause_t;

    // Exception strobes from the pipeline, listed in priority order
    typedef struct packed {
        logic breakpoint;
        logic insn_access;
        logic illegal_insn;
        logic insn_mal;
        logic ecall_m;
        logic mal_s;
        logic mal_l;
        logic fault_s;
        logic fault_l;
    } ex_req_t;

    // Everything captured into the CSRs when a trap is accepted
    typedef struct packed {
        mcause_t           cause;
        logic [XLEN-1:0]   epc;
        logic [XLEN-1:0]   tval;
    } trap_info_t;

endpackage

// ==== hdl/priv_unit.sv ====
// Machine-mode trap unit top level
// Connects the prioritizer, sequencer, timer and CSR file

`timescale 1ns/1ps

module priv_unit import priv_pkg::*; #(
    parameter int PRESCALE = 4  // Clocks per mtime tick
) (
    input  logic             CLK,
    input  logic             nRST,
    input  ex_req_t          ex_req,
    input  logic [XLEN-1:0]  epc,
    input  logic [XLEN-1:0]  bad_addr,
    input  logic             ext_irq,
    input  logic             mret,
    input  logic             pipe_clear,
    input  logic             csr_we,
    input  csr_addr_t        csr_addr,
    input  logic [XLEN-1:0]  csr_wdata,
    output logic             intr,
    output logic [XLEN-1:0]  csr_rdata,
    output mstatus_t         mstatus,
    output mcause_t          mcause,
    output logic [XLEN-1:0]  mepc,
    output logic [XLEN-1:0]  mtval,
    output mip_t             mip
);

    mstatus_t        cur_mstatus;
    mie_t            cur_mie;
    mip_t            cur_mip;
    logic            trap_valid;
    trap_info_t      trap_info;
    logic            capture, commit, restore;
    logic            mtip, mtimecmp_we;
    logic [XLEN-1:0] mtimecmp;

    assign mstatus = cur_mstatus;
    assign mip     = cur_mip;

    trap_prioritizer u_trap_prioritizer (
        .ex_req, .epc, .bad_addr, .cur_mstatus, .cur_mie, .cur_mip,
        .trap_valid, .trap_info
    );

    trap_sequencer u_trap_sequencer (
        .CLK, .nRST, .trap_valid, .pipe_clear, .mret,
        .capture, .commit, .restore, .intr
    );

    mtime_timer #(.PRESCALE(PRESCALE)) u_mtime_timer (
        .CLK, .nRST, .cmp_we(mtimecmp_we), .cmp_wdata(csr_wdata), .mtimecmp, .mtip
    );

    machine_csrs u_machine_csrs (
        .CLK, .nRST, .capture, .commit, .restore, .trap_info, .ext_irq, .mtip,
        .csr_we, .csr_addr, .csr_wdata, .mtimecmp, .csr_rdata, .mtimecmp_we,
        .mstatus(cur_mstatus), .mie(cur_mie), .mip(cur_mip), .mcause, .mepc, .mtval
    );

endmodule

// ==== hdl/trap_prioritizer.sv ====
// Trap prioritizer
// Exception priority chain and eligible interrupt priority chain
// Merges the winner into mcause, epc and tval for the sequencer

`timescale 1ns/1ps

module trap_prioritizer import priv_pkg::*; (
    input  ex_req_t          ex_req,
    input  logic [XLEN-1:0]  epc,
    input  logic [XLEN-1:0]  bad_addr,
    input  mstatus_t         cur_mstatus,
    input  mie_t             cur_mie,
    input  mip_t             cur_mip,
    output logic             trap_valid,
    output trap_info_t       trap_info
);

    ex_code_t  ex_src;
    logic      exception;
    logic      ex_has_tval; // Exception reports the faulting address

    int_code_t int_src;
    logic      interrupt;
    logic      ext_ok, soft_ok, timer_ok;

    // Exception chain, first match wins
    always_comb begin
        exception   = 1'b1;
        ex_has_tval = 1'b1;
        ex_src      = INSN_MAL;

        if (ex_req.breakpoint) begin
            ex_src      = BREAKPOINT;
            ex_has_tval = 1'b0;
        end
        else if (ex_req.insn_access) begin
            ex_src = INSN_ACCESS;
        end
        else if (ex_req.illegal_insn) begin
            ex_src = ILLEGAL_INSN;
        end
        else if (ex_req.insn_mal) begin
            ex_src = INSN_MAL;
        end
        else if (ex_req.ecall_m) begin
            ex_src      = ENV_CALL_M;
            ex_has_tval = 1'b0; // ecall carries no address
        end
        else if (ex_req.mal_s) begin
            ex_src = S_ADDR_MAL;
        end
        else if (ex_req.mal_l) begin
            ex_src = L_ADDR_MAL;
        end
        else if (ex_req.fault_s) begin
            ex_src = S_FAULT;
        end
        else if (ex_req.fault_l) begin
            ex_src = L_FAULT;
        end
        else begin
            exception   = 1'b0;
            ex_has_tval = 1'b0;
        end
    end

    // A source counts only if globally enabled, locally enabled and pending
    assign ext_ok   = cur_mstatus.mie & cur_mie.meie & cur_mip.meip;
    assign soft_ok  = cur_mstatus.mie & cur_mie.msie & cur_mip.msip;
    assign timer_ok = cur_mstatus.mie & cur_mie.mtie & cur_mip.mtip;

    // Interrupt chain, external over software over timer
    always_comb begin
        interrupt = 1'b1;
        int_src   = SOFT_INT_M;

        if (ext_ok) begin
            int_src = EXT_INT_M;
        end
        else if (soft_ok) begin
            int_src = SOFT_INT_M;
        end
        else if (timer_ok) begin
            int_src = TIMER_INT_M;
        end
        else begin
            interrupt = 1'b0;
        end
    end

    assign trap_valid = exception | interrupt;

    // Exceptions always beat interrupts
    always_comb begin
        trap_info.epc = epc; // PC of the faulting or interrupted instruction
        if (exception) begin
            trap_info.cause.interrupt = 1'b0;
            trap_info.cause.cause     = ex_src;
            trap_info.tval            = ex_has_tval ? bad_addr : '0;
        end
        else begin
            trap_info.cause.interrupt = interrupt;
            trap_info.cause.cause     = int_src;
            trap_info.tval            = '0; // Interrupts have no tval
        end
    end

endmodule

// ==== hdl/trap_sequencer.sv ====
// Trap sequencer
// Two-state FSM, IDLE and PENDING
// Latches an accepted trap, holds intr until pipe_clear,
// and emits one-cycle capture, commit and restore strobes

`timescale 1ns/1ps

module trap_sequencer (
    input  logic CLK,
    input  logic nRST,
    input  logic trap_valid,
    input  logic pipe_clear,
    input  logic mret,
    output logic capture,   // Load mcause, mepc, mtval
    output logic commit,    // mpie <= mie, mie <= 0
    output logic restore,   // mret handling of mstatus
    output logic intr
);

    typedef enum logic {
        IDLE,
        PENDING
    } state_t;

    state_t state, next_state;

    // Strobes are decoded from the current state only
    assign capture = (state == IDLE) & trap_valid;
    assign commit  = (state == PENDING) & pipe_clear;
    assign restore = (state == IDLE) & mret;

    // Trap request to the pipeline is the registered PENDING state
    assign intr = (state == PENDING);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (trap_valid) begin
                    next_state = PENDING;
                end
            end
            PENDING: begin
                // New traps are ignored here; wait for the pipeline
                if (pipe_clear) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end
        else begin
            state <= next_state;
        end
    end

endmodule

// ==== tb/priv_unit_tb.sv ====
// Self-checking testbench for the machine-mode trap unit
// Replays the trap vector file with eight words per vector
// Words are opcode, three operands and the expected mcause, mepc, mtval and mstatus image

`timescale 1ns/1ps

module priv_unit_tb import priv_pkg::*; ();

    localparam int PRESCALE = 4;
    localparam int MAX_VEC  = 64;
    localparam int RST_CYC  = 16;

    // Vector opcodes
    localparam logic [31:0] OP_CSR_WR    = 32'h1;
    localparam logic [31:0] OP_CSR_RD    = 32'h2;
    localparam logic [31:0] OP_EXCEPT    = 32'h3;
    localparam logic [31:0] OP_IRQ       = 32'h4;
    localparam logic [31:0] OP_CLEAR     = 32'h5;
    localparam logic [31:0] OP_MRET      = 32'h6;
    localparam logic [31:0] OP_WAIT_INTR = 32'h7; // Bounded wait scaled by mtimecmp in a0
    localparam logic [31:0] OP_QUIET     = 32'h8; // intr must stay low
    localparam logic [31:0] OP_END       = 32'hF;

    logic            CLK, nRST;
    ex_req_t         ex_req;
    logic [XLEN-1:0] epc, bad_addr, csr_wdata;
    logic            ext_irq, mret, pipe_clear, csr_we;
    csr_addr_t       csr_addr;
    logic            intr;
    logic [XLEN-1:0] csr_rdata, mepc, mtval;
    mstatus_t        mstatus;
    mcause_t         mcause;
    mip_t            mip;

    logic [31:0] vec_mem [0:MAX_VEC*8-1];
    int          num_vec, idx, errors, checks, limit;
    int          cycle_cnt = 0;

    priv_unit #(.PRESCALE(PRESCALE)) u_priv_unit (.*);

    always #10 CLK = ~CLK; // 20 ns period

    // Watchdog sized from the vector count
    always @(posedge CLK) begin
        cycle_cnt++;
        if (limit > 0 && cycle_cnt > limit) begin
            $display("Run stopped: vectors did not finish within %0d cycles", limit);
            $display("Checks: %0d  Errors: %0d", checks, errors + 1);
            $display("Errors found");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge CLK);
        #2; // Drive point after the edge
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Software view of mstatus with mpie at bit 7 and mie at bit 3
    function automatic logic [31:0] status_word(input mstatus_t s);
        return {24'b0, s.mpie, 3'b0, s.mie, 3'b0};
    endfunction

    task automatic run_vector(input int v);
        logic [31:0] op, a0, a1, a2;
        logic [31:0] e_cause, e_epc, e_tval, e_stat;
        int          n;
        op      = vec_mem[v*8];
        a0      = vec_mem[v*8+1];
        a1      = vec_mem[v*8+2];
        a2      = vec_mem[v*8+3];
        e_cause = vec_mem[v*8+4];
        e_epc   = vec_mem[v*8+5];
        e_tval  = vec_mem[v*8+6];
        e_stat  = vec_mem[v*8+7];
        case (op)
            OP_CSR_WR: begin
                csr_we    = 1'b1;
                csr_addr  = a0[11:0];
                csr_wdata = a1;
                next_cycle();
                csr_we = 1'b0;
            end
            OP_CSR_RD: begin
                csr_addr = a0[11:0];
                #5; // Mid cycle sample of the combinational read port
                check_value("csr_rdata", csr_rdata, a1);
                next_cycle();
            end
            OP_EXCEPT: begin
                ex_req   = ex_req_t'(a0[8:0]);
                epc      = a1;
                bad_addr = a2;
                next_cycle();
                ex_req = '0;
                check_value("intr", {31'b0, intr}, 32'h1); // High the cycle after
            end
            OP_IRQ: begin
                ext_irq = a0[0];
                epc     = a1; // PC of the interrupted instruction
                next_cycle();
                // meip trails ext_irq by one register stage
                check_value("mip.meip", {31'b0, mip.meip}, {31'b0, a0[0]});
            end
            OP_CLEAR: begin
                for (n = 0; n <= a0; n++) begin
                    check_value("intr", {31'b0, intr}, 32'h1); // Held while pending
                    if (n < a0) next_cycle();
                end
                pipe_clear = 1'b1;
                next_cycle();
                pipe_clear = 1'b0;
                check_value("intr", {31'b0, intr}, 32'h0);
                check_value("mcause", mcause, e_cause);
                check_value("mepc", mepc, e_epc);
                check_value("mtval", mtval, e_tval);
                check_value("mstatus", status_word(mstatus), e_stat);
            end
            OP_MRET: begin
                mret = 1'b1;
                next_cycle();
                mret = 1'b0;
                check_value("mstatus", status_word(mstatus), e_stat);
            end
            OP_WAIT_INTR: begin
                n = 0;
                while (!intr && n < PRESCALE * (a0 + 2)) begin
                    next_cycle();
                    n++;
                end
                checks++;
                if (!intr) begin
                    errors++;
                    $display("Interrupt not raised within %0d cycles at %0t ns", n, $time);
                end
            end
            OP_QUIET: begin
                for (n = 0; n < a0; n++) begin
                    check_value("intr", {31'b0, intr}, 32'h0);
                    next_cycle();
                end
            end
            default: begin
                errors++;
                $display("Unknown opcode %h in vector %0d", op, v);
            end
        endcase
    endtask

    initial begin
        CLK        = 1'b0;
        nRST       = 1'b0;
        ex_req     = '0;
        epc        = '0;
        bad_addr   = '0;
        ext_irq    = 1'b0;
        mret       = 1'b0;
        pipe_clear = 1'b0;
        csr_we     = 1'b0;
        csr_addr   = '0;
        csr_wdata  = '0;
        errors     = 0;
        checks     = 0;
        num_vec    = 0;
        limit      = 0;
        $readmemh("tb/trap_input.hex", vec_mem);
        while (num_vec < MAX_VEC && vec_mem[num_vec*8] !== OP_END) num_vec++;
        limit = RST_CYC + num_vec * 64;
        repeat (RST_CYC) @(posedge CLK);
        #2 nRST = 1'b1;
        next_cycle();
        for (idx = 0; idx < num_vec; idx++) run_vector(idx);
        $display("Vectors: %0d  Checks: %0d  Errors: %0d", num_vec, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end
        else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== tb/trap_input.hex ====
// op a0(addr/strobes/level/cycles) a1(data/epc) a2(bad_addr) mcause mepc mtval mstatus
// op 1 csr wr, 2 csr rd, 3 exception, 4 irq level, 5 pipe_clear, 6 mret, 7 wait intr, 8 no intr, F end
3 00000049 00001000 DEADBEEF 00000000 00000000 00000000 00000000
3 00000100 00002000 12345678 00000000 00000000 00000000 00000000
5 00000003 00000000 00000000 00000002 00001000 DEADBEEF 00000000
1 00000300 FFFFFFFF 00000000 00000000 00000000 00000000 00000000
2 00000300 00000088 00000000 00000000 00000000 00000000 00000000
3 00000190 00002004 CAFE0000 00000000 00000000 00000000 00000000
5 00000002 00000000 00000000 00000003 00002004 00000000 00000080
6 00000000 00000000 00000000 00000000 00000000 00000000 00000008
3 00000006 0000400C 80000003 00000000 00000000 00000000 00000000
5 00000000 00000000 00000000 00000004 0000400C 80000003 00000080
1 00000304 FFFFFFFF 00000000 00000000 00000000 00000000 00000000
2 00000304 00000888 00000000 00000000 00000000 00000000 00000000
1 00000344 00000008 00000000 00000000 00000000 00000000 00000000
4 00000001 00005010 00000000 00000000 00000000 00000000 00000000
8 00000008 00000000 00000000 00000000 00000000 00000000 00000000
6 00000000 00000000 00000000 00000000 00000000 00000000 00000008
7 00000000 00000000 00000000 00000000 00000000 00000000 00000000
5 00000000 00000000 00000000 8000000B 00005010 00000000 00000080
4 00000000 00006000 00000000 00000000 00000000 00000000 00000000
1 00000344 00000000 00000000 00000000 00000000 00000000 00000000
1 000007C0 00000030 00000000 00000000 00000000 00000000 00000000
6 00000000 00000000 00000000 00000000 00000000 00000000 00000008
7 00000030 00000000 00000000 00000000 00000000 00000000 00000000
1 000007C0 FFFFFFFF 00000000 00000000 00000000 00000000 00000000
5 00000001 00000000 00000000 80000007 00006000 00000000 00000080
1 00000341 FFFFFFFF 00000000 00000000 00000000 00000000 00000000
2 00000341 FFFFFFFC 00000000 00000000 00000000 00000000 00000000
F 00000000 00000000 00000000 00000000 00000000 00000000 00000000
